// ==== fp_pkg.sv ====
package fp_pkg;

    // single precision field widths
    // top level takes these as parameter defaults
    localparam int fp_exp_w = 8;

    // stored fraction only without the hidden bit
    localparam int fp_man_w = 23;

    // operation select
    // sub flips the sign of b before alignment
    typedef enum logic {
        fp_op_add = 1'b0,
        fp_op_sub = 1'b1
    } fp_op_e;

    // one register per stage
    // align, mantissa add/sub, normalize
    localparam int fp_latency = 3;

endpackage

// ==== fp_align.sv ====
`timescale 1ns/1ps

module fp_align
    import fp_pkg::*;
#(
    parameter int exp_w = fp_exp_w,
    parameter int man_w = fp_man_w
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [exp_w+man_w:0] a,
    input  logic [exp_w+man_w:0] b,
    input  fp_op_e               op,
    output logic                 s1_valid,
    output logic                 s1_sign_big,
    output logic                 s1_sign_small,
    output logic [exp_w-1:0]     s1_exp,
    output logic [man_w:0]       s1_man_big,
    output logic [man_w:0]       s1_man_small
);

    // unpacked operand fields
    logic             sign_a;
    logic             sign_b;
    logic [exp_w-1:0] exp_a;
    logic [exp_w-1:0] exp_b;
    // mantissas with the implicit one in front
    logic [man_w:0]   man_a;
    logic [man_w:0]   man_b;

    // big/small selection
    logic             a_big;
    logic             sign_big;
    logic             sign_small;
    logic [exp_w-1:0] exp_big;
    logic [exp_w-1:0] exp_diff;
    logic [man_w:0]   man_big;
    logic [man_w:0]   man_small;

    assign sign_a = a[exp_w+man_w];
    assign exp_a  = a[exp_w+man_w-1:man_w];
    assign man_a  = {1'b1, a[man_w-1:0]};

    // subtract is add with b negated
    assign sign_b = b[exp_w+man_w] ^ (op == fp_op_sub);
    assign exp_b  = b[exp_w+man_w-1:man_w];
    assign man_b  = {1'b1, b[man_w-1:0]};

    // a wins only on a strictly larger exponent so ties go to b
    assign a_big = (exp_a > exp_b);

    always_comb begin
        if (a_big) begin
            sign_big   = sign_a;
            sign_small = sign_b;
            exp_big    = exp_a;
            exp_diff   = exp_a - exp_b;
            man_big    = man_a;
            man_small  = man_b;
        end else begin
            sign_big   = sign_b;
            sign_small = sign_a;
            exp_big    = exp_b;
            exp_diff   = exp_b - exp_a;
            man_big    = man_b;
            man_small  = man_a;
        end
    end

    // stage 1 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid      <= 1'b0;
            s1_sign_big   <= 1'b0;
            s1_sign_small <= 1'b0;
            s1_exp        <= '0;
            s1_man_big    <= '0;
            s1_man_small  <= '0;
        end else begin
            s1_valid <= in_valid;
            if (in_valid) begin
                s1_sign_big   <= sign_big;
                s1_sign_small <= sign_small;
                s1_exp        <= exp_big;
                s1_man_big    <= man_big;
                // whole mantissa shifted out so nothing is left to add
                if (exp_diff >= man_w + 1) begin
                    s1_man_small <= '0;
                end else begin
                    // truncating shift drops the lost bits
                    s1_man_small <= man_small >> exp_diff;
                end
            end
        end
    end

endmodule

// ==== fp_mant_addsub.sv ====
`timescale 1ns/1ps

module fp_mant_addsub
    import fp_pkg::*;
#(
    parameter int exp_w = fp_exp_w,
    parameter int man_w = fp_man_w
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               s1_valid,
    input  logic               s1_sign_big,
    input  logic               s1_sign_small,
    input  logic [exp_w-1:0]   s1_exp,
    input  logic [man_w:0]     s1_man_big,
    input  logic [man_w:0]     s1_man_small,
    output logic               s2_valid,
    output logic               s2_sign,
    output logic [exp_w-1:0]   s2_exp,
    output logic [man_w+1:0]   s2_sum
);

    // one extra bit on top for the carry
    logic [man_w+1:0] sum;
    logic             sign;

    always_comb begin
        if (s1_sign_big == s1_sign_small) begin
            // like signs add the magnitudes
            sum  = {1'b0, s1_man_big} + {1'b0, s1_man_small};
            sign = s1_sign_big;
        end else if (s1_man_big > s1_man_small) begin
            sum  = {1'b0, s1_man_big} - {1'b0, s1_man_small};
            sign = s1_sign_big;
        end else if (s1_man_small > s1_man_big) begin
            // only possible on equal exponents
            sum  = {1'b0, s1_man_small} - {1'b0, s1_man_big};
            sign = s1_sign_small;
        end else begin
            // exact cancellation gives +0
            sum  = '0;
            sign = 1'b0;
        end
    end

    // stage 2 register with the exponent riding along
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
            s2_sign  <= 1'b0;
            s2_exp   <= '0;
            s2_sum   <= '0;
        end else begin
            s2_valid <= s1_valid;
            if (s1_valid) begin
                s2_sign <= sign;
                s2_exp  <= s1_exp;
                s2_sum  <= sum;
            end
        end
    end

endmodule

// ==== fp_normalize.sv ====
`timescale 1ns/1ps

module fp_normalize
    import fp_pkg::*;
#(
    parameter int exp_w = fp_exp_w,
    parameter int man_w = fp_man_w
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 s2_valid,
    input  logic                 s2_sign,
    input  logic [exp_w-1:0]     s2_exp,
    input  logic [man_w+1:0]     s2_sum,
    output logic                 out_valid,
    output logic [exp_w+man_w:0] result,
    output logic                 overflow,
    output logic                 underflow
);

    // signed exponent with two guard bits
    localparam int ew   = exp_w + 2;
    // enough bits to count 0..man_w leading zeros
    localparam int lz_w = $clog2(man_w + 2);
    // all ones exponent is reserved for infinity
    localparam logic signed [ew-1:0] exp_max = $signed({2'b00, {exp_w{1'b1}}});

    logic [lz_w-1:0]      lz;
    logic [man_w:0]       norm_man;
    logic signed [ew-1:0] norm_exp;
    logic                 sum_zero;
    logic                 ovf;
    logic                 unf;
    logic [exp_w+man_w:0] packed_res;

    assign sum_zero = (s2_sum == '0);

    // leading zero count below the carry bit
    // scan upward so the highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i <= man_w; i++) begin
            if (s2_sum[i]) begin
                lz = lz_w'(man_w - i);
            end
        end
    end

    always_comb begin
        if (s2_sum[man_w+1]) begin
            // carry out shifts one place right
            norm_man = s2_sum[man_w+1:1];
            norm_exp = $signed({2'b00, s2_exp}) + 1;
        end else begin
            // bring the leading one up to the hidden bit
            norm_man = s2_sum[man_w:0] << lz;
            norm_exp = $signed({2'b00, s2_exp}) - $signed({1'b0, lz});
        end
    end

    // clamp and pack
    always_comb begin
        ovf = 1'b0;
        unf = 1'b0;
        if (sum_zero) begin
            // cancellation always reports +0
            packed_res = '0;
            unf        = 1'b1;
        end else if (norm_exp >= exp_max) begin
            // signed infinity
            packed_res = {s2_sign, {exp_w{1'b1}}, {man_w{1'b0}}};
            ovf        = 1'b1;
        end else if (norm_exp <= 0) begin
            // no denormals so flush to signed zero
            packed_res = {s2_sign, {(exp_w + man_w){1'b0}}};
            unf        = 1'b1;
        end else begin
            // hidden bit dropped on the way out
            packed_res = {s2_sign, norm_exp[exp_w-1:0], norm_man[man_w-1:0]};
        end
    end

    // stage 3 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            out_valid <= s2_valid;
            if (s2_valid) begin
                result    <= packed_res;
                overflow  <= ovf;
                underflow <= unf;
            end
        end
    end

endmodule

// ==== fp_add_pipe.sv ====
`timescale 1ns/1ps

module fp_add_pipe
    import fp_pkg::*;
#(
    parameter int exp_w = fp_exp_w,
    parameter int man_w = fp_man_w
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [exp_w+man_w:0] a,
    input  logic [exp_w+man_w:0] b,
    input  fp_op_e               op,
    output logic                 out_valid,
    output logic [exp_w+man_w:0] result,
    output logic                 overflow,
    output logic                 underflow
);

    // align to add/sub
    logic             s1_valid;
    logic             s1_sign_big;
    logic             s1_sign_small;
    logic [exp_w-1:0] s1_exp;
    logic [man_w:0]   s1_man_big;
    logic [man_w:0]   s1_man_small;

    // add/sub to normalize
    logic             s2_valid;
    logic             s2_sign;
    logic [exp_w-1:0] s2_exp;
    logic [man_w+1:0] s2_sum;

    // stage 1 compares exponents and shifts the small mantissa
    fp_align #(
        .exp_w (exp_w),
        .man_w (man_w)
    ) u_align (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .a             (a),
        .b             (b),
        .op            (op),
        .s1_valid      (s1_valid),
        .s1_sign_big   (s1_sign_big),
        .s1_sign_small (s1_sign_small),
        .s1_exp        (s1_exp),
        .s1_man_big    (s1_man_big),
        .s1_man_small  (s1_man_small)
    );

    // stage 2 does the signed magnitude add
    fp_mant_addsub #(
        .exp_w (exp_w),
        .man_w (man_w)
    ) u_addsub (
        .clk           (clk),
        .rst_n         (rst_n),
        .s1_valid      (s1_valid),
        .s1_sign_big   (s1_sign_big),
        .s1_sign_small (s1_sign_small),
        .s1_exp        (s1_exp),
        .s1_man_big    (s1_man_big),
        .s1_man_small  (s1_man_small),
        .s2_valid      (s2_valid),
        .s2_sign       (s2_sign),
        .s2_exp        (s2_exp),
        .s2_sum        (s2_sum)
    );

    // stage 3 normalizes, clamps and packs
    fp_normalize #(
        .exp_w (exp_w),
        .man_w (man_w)
    ) u_norm (
        .clk       (clk),
        .rst_n     (rst_n),
        .s2_valid  (s2_valid),
        .s2_sign   (s2_sign),
        .s2_exp    (s2_exp),
        .s2_sum    (s2_sum),
        .out_valid (out_valid),
        .result    (result),
        .overflow  (overflow),
        .underflow (underflow)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns = 20
) (
    output logic clk
);

    // free running clock that starts low
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

// ==== tb_fp_add_pipe.sv ====
`timescale 1ns/1ps

module tb_fp_add_pipe
    import fp_pkg::*;
;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] a;
    logic [31:0] b;
    fp_op_e      op;
    logic        out_valid;
    logic [31:0] result;
    logic        overflow;
    logic        underflow;

    // each entry holds a, b, sub, ovf, unf and result
    logic [98:0] expect_q[$:4 * fp_latency + 16];
    logic [98:0] mon_entry;
    logic [31:0] rng;
    int          err_count;
    int          err_mark;
    int          pass_tests;
    int          fail_tests;
    int          sent_count;
    int          recv_count;

    tb_clock_gen #(.period_ns(20)) u_clk_gen (.clk(clk));

    fp_add_pipe #(
        .exp_w (fp_exp_w),
        .man_w (fp_man_w)
    ) u_fp_add_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .op        (op),
        .out_valid (out_valid),
        .result    (result),
        .overflow  (overflow),
        .underflow (underflow)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // reference model returning {ovf, unf, packed result}
    // truncating with no denormals
    function automatic logic [33:0] model_add(input logic [31:0] x, input logic [31:0] y,
                                              input logic sub);
        logic   s_x, s_y, s_big, s_small, s_res, ovf, unf;
        int     e_x, e_y, e_big, e_small, e_res;
        longint m_x, m_y, m_big, m_small, sum;
        logic [31:0] res;
        s_x = x[31];
        s_y = y[31] ^ sub;
        e_x = int'(x[30:23]);
        e_y = int'(y[30:23]);
        m_x = longint'({1'b1, x[22:0]});
        m_y = longint'({1'b1, y[22:0]});
        // equal exponents pick y as the big one
        if (e_x > e_y) begin
            s_big = s_x;
            e_big = e_x;
            m_big = m_x;
            s_small = s_y;
            e_small = e_y;
            m_small = m_y;
        end else begin
            s_big = s_y;
            e_big = e_y;
            m_big = m_y;
            s_small = s_x;
            e_small = e_x;
            m_small = m_x;
        end
        m_small = (e_big - e_small > 23) ? 64'sd0 : (m_small >> (e_big - e_small));
        if (s_big == s_small) begin
            sum = m_big + m_small;
            s_res = s_big;
        end else if (m_big > m_small) begin
            sum = m_big - m_small;
            s_res = s_big;
        end else if (m_small > m_big) begin
            sum = m_small - m_big;
            s_res = s_small;
        end else begin
            sum = 0;
            s_res = 1'b0;
        end
        ovf = 1'b0;
        unf = 1'b0;
        e_res = e_big;
        if (sum == 0) begin
            res = 32'h0;
            unf = 1'b1;
        end else begin
            if (sum >= 64'sd16777216) begin
                sum = sum >> 1;
                e_res = e_res + 1;
            end
            while (sum < 64'sd8388608) begin
                sum = sum << 1;
                e_res = e_res - 1;
            end
            if (e_res >= 255) begin
                res = {s_res, 8'hFF, 23'h0};
                ovf = 1'b1;
            end else if (e_res <= 0) begin
                res = {s_res, 31'h0};
                unf = 1'b1;
            end else begin
                res = {s_res, e_res[7:0], sum[22:0]};
            end
        end
        return {ovf, unf, res};
    endfunction

    task automatic send(input logic [31:0] x, input logic [31:0] y, input logic sub);
        @(negedge clk);
        in_valid = 1'b1;
        a = x;
        b = y;
        op = sub ? fp_op_sub : fp_op_add;
        expect_q.push_back({x, y, sub, model_add(x, y, sub)});
        sent_count++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // bounded wait for every queued result
    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (expect_q.size() != 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("timeout: %0d results never came out of the pipeline", expect_q.size());
            $display("TEST FAILED");
            $finish;
        end
    endtask

    task automatic close_test(input string name);
        if (err_count == err_mark) begin
            pass_tests++;
            $display("[done] %s: pass", name);
        end else begin
            fail_tests++;
            $display("[done] %s: %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    // registered outputs still hold the old value at the edge
    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            recv_count++;
            if (expect_q.size() == 0) begin
                $display("error at %0t: out_valid with no operation in flight", $time);
                err_count++;
            end else begin
                mon_entry = expect_q.pop_front();
                if ({overflow, underflow, result} !== mon_entry[33:0]) begin
                    $display("[FAIL] %0t a=%h b=%h sub=%0b got %h o%0b u%0b exp %h o%0b u%0b",
                             $time, mon_entry[98:67], mon_entry[66:35], mon_entry[34],
                             result, overflow, underflow,
                             mon_entry[31:0], mon_entry[33], mon_entry[32]);
                    err_count++;
                end
            end
        end
    end

    initial begin
        int          k;
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] ctl;
        logic [22:0] m;
        rst_n = 1'b0;
        in_valid = 1'b0;
        a = 32'h0;
        b = 32'h0;
        op = fp_op_add;
        rng = 32'd4;
        err_count = 0;
        err_mark = 0;
        pass_tests = 0;
        fail_tests = 0;
        sent_count = 0;
        recv_count = 0;

        // out_valid must stay low through reset and idle cycles
        repeat (5) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("[FAIL] %0t out_valid=%b during reset", $time, out_valid);
                err_count++;
            end
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("[FAIL] %0t out_valid=%b after reset, nothing sent", $time, out_valid);
                err_count++;
            end
        end
        send(32'h3F800000, 32'h3F800000, 1'b0);
        drain();
        close_test("reset state");

        // 1.5+2.25 then a carry on equal exponents and a vanishing small operand
        send(32'h3FC00000, 32'h40100000, 1'b0);
        send(32'h3FC00000, 32'h3FC00000, 1'b0);
        send(32'h3F800000, 32'h30800000, 1'b0);
        send(32'hBFC00000, 32'hC0100000, 1'b0);
        send(32'h4B7FFFFF, 32'h3F800000, 1'b0);
        drain();
        close_test("same-sign add");

        // both operand orders with the flipped-sign add next to each
        send(32'h40100000, 32'h3FC00000, 1'b1);
        send(32'h40100000, 32'hBFC00000, 1'b0);
        send(32'h3FC00000, 32'h40100000, 1'b1);
        send(32'h3FC00000, 32'hC0100000, 1'b0);
        send(32'hC1200000, 32'h3E800000, 1'b1);
        drain();
        close_test("subtract op");

        // difference of 2^(23-k) ulps leaves k leading zeros
        for (k = 1; k <= 23; k++) begin
            m = 23'h7FFFFF - 23'(1 << (23 - k));
            send({1'b0, 8'd130, 23'h7FFFFF}, {1'b1, 8'd130, m}, 1'b0);
        end
        send(32'h40490FDB, 32'hC0490FDB, 1'b0);
        send(32'h40490FDB, 32'h40490FDB, 1'b1);
        drain();
        close_test("cancellation");

        // past the top exponent and below one
        send(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0);
        send(32'hFF7FFFFF, 32'hFF7FFFFF, 1'b0);
        send(32'h7F000000, 32'hFF000000, 1'b1);
        send({1'b0, 8'd1, 23'h000001}, {1'b1, 8'd1, 23'h000000}, 1'b0);
        send({1'b1, 8'd1, 23'h000001}, {1'b0, 8'd1, 23'h000000}, 1'b0);
        send(32'h00800001, 32'h00800000, 1'b1);
        drain();
        close_test("overflow/underflow clamps");

        sent_count = 0;
        recv_count = 0;
        for (k = 0; k < 500; k++) begin
            rng = xorshift32(rng);
            ra = rng;
            rng = xorshift32(rng);
            rb = rng;
            rng = xorshift32(rng);
            ctl = rng;
            // exponent 255 is outside the input range
            if (ra[30:23] == 8'hFF) ra[30:23] = 8'hFE;
            // half the pairs get close exponents so mantissas interact
            if (ctl[1]) rb[30:23] = ra[30:23] - {5'd0, ctl[4:2]};
            if (rb[30:23] == 8'hFF) rb[30:23] = 8'hFE;
            send(ra, rb, ctl[0]);
            if (ctl[7:5] == 3'd0) idle(int'(ctl[9:8]) + 1);
        end
        drain();
        // quiet window so stray out_valid pulses are counted too
        idle(fp_latency + 1);
        if (recv_count != sent_count) begin
            $display("[FAIL] %0t sent %0d, received %0d", $time, sent_count, recv_count);
            err_count++;
        end
        close_test("streaming");

        $display("tests passed %0d, failed %0d, value errors %0d",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
fp_pkg.sv
fp_align.sv
fp_mant_addsub.sv
fp_normalize.sv
fp_add_pipe.sv
tb_clock_gen.sv
tb_fp_add_pipe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the FP add pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_fp_add_pipe \
    -f sources.f \
    --Mdir obj_dir \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
